/* fetch_cache_macros.svh */
`ifndef FETCH_CACHE_MACROS_SVH
`define FETCH_CACHE_MACROS_SVH

// byte address width seen by the sequencer and the wishbone bus
`define ADDR_W 32

// direct mapped, 256 lines of 32 bytes each (8 KiB)
`define LINE_COUNT 256
`define LINE_HW 16

// set index picks one of LINE_COUNT lines
`define INDEX_W $clog2(`LINE_COUNT)

// byte offset inside a line, halfword offset plus the byte bit
`define OFFSET_W ($clog2(`LINE_HW) + 1)

// whatever is left of the address above index and offset
`define TAG_W (`ADDR_W - `INDEX_W - `OFFSET_W)

`endif

/* fetch_cache_pkg.sv */
`include "fetch_cache_macros.svh"

package fetch_cache_pkg;

   // one delivered instruction, opcode plus the 32 bits that follow it
   typedef struct packed {
      logic [`ADDR_W-1:0] pc;
      logic [15:0]        opcode;
      // halfword at pc+2 in the upper half, pc+4 in the lower half
      logic [31:0]        imm;
      logic [2:0]         len;
   } fetch_bundle_t;

   // wishbone master outputs of the cache
   typedef struct packed {
      logic [`ADDR_W-1:0] adr;
      logic [1:0]         sel;
      logic               cyc;
      logic               stb;
   } wb_req_t;

   // registered answer of the cache to one lookup address
   typedef struct packed {
      logic        hit;
      logic [15:0] opcode;
      logic [31:0] imm;
   } lookup_rsp_t;

   // instruction length in bytes from the opcode alone
   function automatic logic [2:0] insn_len(input logic [15:0] opcode);
      logic [2:0] len;
      // form 2 opcodes are always a single halfword
      if (opcode[15])
         len = 3'd2;
      else
      begin
         case (opcode[14:13])
            2'b00:   len = 3'd2;
            2'b01:   len = 3'd4;
            default: len = 3'd6;
         endcase
      end
      return len;
   endfunction

endpackage

/* icache.sv */
`timescale 1ns/1ps
`include "fetch_cache_macros.svh"

module icache
   import fetch_cache_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic [`ADDR_W-1:0] lookup_adr_i,
   input  logic               lookup_stb_i,
   output lookup_rsp_t        lookup_rsp_o,
   output wb_req_t            wb_o,
   input  logic [15:0]        wb_dat_i,
   input  logic               wb_ack_i
);

   // address layout: tag | set | halfword offset | byte bit
   localparam int OFF_W  = $clog2(`LINE_HW);
   localparam int SET_LO = OFF_W + 1;
   localparam int TAG_LO = SET_LO + `INDEX_W;
   localparam int HW_W   = `INDEX_W + OFF_W;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FILL,
      ST_WAIT
   } fill_state_t;

   // cache arrays, valid bits live in a flat vector so reset can clear them
   logic [`LINE_COUNT-1:0] valid_q;
   logic [`TAG_W-1:0]      tag_mem [`LINE_COUNT];
   logic [15:0]            line_mem [`LINE_COUNT*`LINE_HW];

   // lookup side
   logic [`ADDR_W-1:0] adr_p2;
   logic [`ADDR_W-1:0] adr_p4;
   logic [`INDEX_W-1:0] set0;
   logic [`INDEX_W-1:0] set1;
   logic [`TAG_W-1:0]   tag0;
   logic [`TAG_W-1:0]   tag1;
   logic                hit0;
   logic                hit1;
   logic [`ADDR_W-1:0]  miss_adr;
   lookup_rsp_t         rsp_q;

   // fill side
   fill_state_t         state_q;
   logic [OFF_W-1:0]    beat_q;
   logic                beat_last;
   logic                wb_stb_q;
   logic [`ADDR_W-1:0]  wb_adr_q;
   logic [`INDEX_W-1:0] fill_set;
   logic [`TAG_W-1:0]   fill_tag;

   // halfwords after the opcode, may run into the next line
   assign adr_p2 = lookup_adr_i + `ADDR_W'(2);
   assign adr_p4 = lookup_adr_i + `ADDR_W'(4);

   // line of the opcode and line of the last immediate halfword
   // pc+2 always sits in one of these two
   assign set0 = lookup_adr_i[TAG_LO-1:SET_LO];
   assign tag0 = lookup_adr_i[`ADDR_W-1:TAG_LO];
   assign set1 = adr_p4[TAG_LO-1:SET_LO];
   // tag taken from pc+4 so a wrap past the last set still compares right
   assign tag1 = adr_p4[`ADDR_W-1:TAG_LO];

   assign hit0 = valid_q[set0] && (tag_mem[set0] == tag0);
   assign hit1 = valid_q[set1] && (tag_mem[set1] == tag1);

   // opcode line first, second line only once the first is present
   assign miss_adr = hit0 ? adr_p4 : lookup_adr_i;

   // response registered every cycle, only the hit flag is control state
   always_ff @(posedge clk_i)
   begin
      rsp_q.opcode <= line_mem[lookup_adr_i[HW_W:1]];
      rsp_q.imm    <= {line_mem[adr_p2[HW_W:1]], line_mem[adr_p4[HW_W:1]]};
      if (rst_i)
         rsp_q.hit <= 1'b0;
      else
         rsp_q.hit <= lookup_stb_i && hit0 && hit1;
   end

   assign lookup_rsp_o = rsp_q;

   // set and tag of the line being filled stay put in the bus address
   assign fill_set  = wb_adr_q[TAG_LO-1:SET_LO];
   assign fill_tag  = wb_adr_q[`ADDR_W-1:TAG_LO];
   assign beat_last = (beat_q == OFF_W'(`LINE_HW - 1));

   // fill controller
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q  <= ST_IDLE;
         beat_q   <= '0;
         wb_stb_q <= 1'b0;
         valid_q  <= '0;
      end
      else
      begin
         case (state_q)
            ST_IDLE:
            begin
               beat_q <= '0;
               if (lookup_stb_i && !(hit0 && hit1))
               begin
                  // start at the line-aligned address of the missing line
                  wb_adr_q <= {miss_adr[`ADDR_W-1:SET_LO], {SET_LO{1'b0}}};
                  wb_stb_q <= 1'b1;
                  // line is overwritten beat by beat, so drop it now
                  valid_q[miss_adr[TAG_LO-1:SET_LO]] <= 1'b0;
                  state_q <= ST_FILL;
               end
            end

            ST_FILL:
            begin
               if (wb_ack_i)
               begin
                  // stb drops for one cycle between beats
                  wb_stb_q <= 1'b0;
                  beat_q   <= beat_q + 1'b1;
                  if (beat_last)
                  begin
                     valid_q[fill_set] <= 1'b1;
                     // back to idle, a straddle re-checks the next line there
                     state_q <= ST_IDLE;
                  end
                  else
                  begin
                     wb_adr_q <= wb_adr_q + `ADDR_W'(2);
                     state_q  <= ST_WAIT;
                  end
               end
            end

            ST_WAIT:
            begin
               wb_stb_q <= 1'b1;
               state_q  <= ST_FILL;
            end

            default:
               state_q <= ST_IDLE;
         endcase
      end
   end

   // line data and tag written from the returning beats
   always_ff @(posedge clk_i)
   begin
      if (state_q == ST_FILL && wb_ack_i)
      begin
         line_mem[{fill_set, beat_q}] <= wb_dat_i;
         if (beat_last)
            tag_mem[fill_set] <= fill_tag;
      end
   end

   // classic cycles only, cyc follows stb, always full halfwords
   assign wb_o.adr = wb_adr_q;
   assign wb_o.sel = 2'b11;
   assign wb_o.cyc = wb_stb_q;
   assign wb_o.stb = wb_stb_q;

endmodule

/* fetch_sequencer.sv */
`timescale 1ns/1ps
`include "fetch_cache_macros.svh"

module fetch_sequencer
   import fetch_cache_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic [`ADDR_W-1:0] reset_pc_i,
   input  logic               redirect_i,
   input  logic [`ADDR_W-1:0] target_i,
   output logic [`ADDR_W-1:0] lookup_adr_o,
   output logic               lookup_stb_o,
   input  lookup_rsp_t        lookup_rsp_i,
   output fetch_bundle_t      bundle_o,
   output logic               bundle_valid_o,
   input  logic               bundle_ready_i
);

   typedef enum logic {
      ST_LOOKUP,
      ST_DELIVER
   } seq_state_t;

   seq_state_t         state_q;
   logic [`ADDR_W-1:0] pc_q;
   logic               stb_q;
   // response this cycle belongs to the current pc
   logic               pend_q;
   fetch_bundle_t      bundle_q;
   logic               take_hit;
   logic               accept;

   // a response only counts if the address was on the bus the cycle before
   assign take_hit = (state_q == ST_LOOKUP) && pend_q && lookup_rsp_i.hit;
   assign accept   = (state_q == ST_DELIVER) && bundle_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q <= ST_LOOKUP;
         pc_q    <= reset_pc_i;
         stb_q   <= 1'b0;
         pend_q  <= 1'b0;
      end
      else if (redirect_i)
      begin
         // drop any held bundle and any lookup in flight
         state_q <= ST_LOOKUP;
         pc_q    <= target_i;
         stb_q   <= 1'b1;
         pend_q  <= 1'b0;
      end
      else
      begin
         pend_q <= stb_q && !take_hit;
         if (take_hit)
         begin
            // stop looking up until the bundle is taken
            state_q <= ST_DELIVER;
            stb_q   <= 1'b0;
         end
         else if (accept)
         begin
            state_q <= ST_LOOKUP;
            pc_q    <= pc_q + `ADDR_W'(bundle_q.len);
            stb_q   <= 1'b1;
         end
         else if (state_q == ST_LOOKUP)
            stb_q <= 1'b1;
      end
   end

   // bundle captured on the hit, held unchanged under back-pressure
   always_ff @(posedge clk_i)
   begin
      if (take_hit)
      begin
         bundle_q.pc     <= pc_q;
         bundle_q.opcode <= lookup_rsp_i.opcode;
         bundle_q.imm    <= lookup_rsp_i.imm;
         bundle_q.len    <= insn_len(lookup_rsp_i.opcode);
      end
   end

   // address held stable for as long as stb is up
   assign lookup_adr_o   = pc_q;
   assign lookup_stb_o   = stb_q;
   assign bundle_o       = bundle_q;
   assign bundle_valid_o = (state_q == ST_DELIVER);

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_cache_macros.svh"

module fetch_top
   import fetch_cache_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic [`ADDR_W-1:0] reset_pc_i,
   input  logic               redirect_i,
   input  logic [`ADDR_W-1:0] target_i,
   output wb_req_t            wb_o,
   input  logic [15:0]        wb_dat_i,
   input  logic               wb_ack_i,
   output fetch_bundle_t      bundle_o,
   output logic               bundle_valid_o,
   input  logic               bundle_ready_i
);

   // sequencer to cache lookup path
   logic [`ADDR_W-1:0] lookup_adr;
   logic               lookup_stb;
   lookup_rsp_t        lookup_rsp;

   fetch_sequencer seq0 (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .reset_pc_i     (reset_pc_i),
      .redirect_i     (redirect_i),
      .target_i       (target_i),
      .lookup_adr_o   (lookup_adr),
      .lookup_stb_o   (lookup_stb),
      .lookup_rsp_i   (lookup_rsp),
      .bundle_o       (bundle_o),
      .bundle_valid_o (bundle_valid_o),
      .bundle_ready_i (bundle_ready_i)
   );

   // cache owns the wishbone side
   icache icache0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .lookup_adr_i (lookup_adr),
      .lookup_stb_i (lookup_stb),
      .lookup_rsp_o (lookup_rsp),
      .wb_o         (wb_o),
      .wb_dat_i     (wb_dat_i),
      .wb_ack_i     (wb_ack_i)
   );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
   output logic clk_o,
   output logic rst_o
);

   // 4 ns period
   initial
   begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   // reset held over the first 4 rising edges
   initial
   begin
      rst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

/* tb_wb_mem.sv */
`timescale 1ns/1ps
`include "fetch_cache_macros.svh"

module tb_wb_mem
   import fetch_cache_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  wb_req_t     wb_i,
   output logic [15:0] dat_o,
   output logic        ack_o
);

   // memory content is the low half of the byte address xor its upper half
   function automatic logic [15:0] mem_word(input logic [`ADDR_W-1:0] a);
      return a[15:0] ^ a[`ADDR_W-1:16];
   endfunction

   initial
   begin
      dat_o = '0;
      ack_o = 1'b0;
   end

   // one wait state, ack comes the cycle after stb is seen
   // and drops again right after the beat
   always @(posedge clk_i)
   begin
      if (rst_i)
      begin
         ack_o <= 1'b0;
         dat_o <= '0;
      end
      else
      begin
         ack_o <= wb_i.cyc && wb_i.stb && !ack_o;
         dat_o <= mem_word(wb_i.adr);
      end
   end

endmodule

/* fetch_sva.sv */
`timescale 1ns/1ps
`include "fetch_cache_macros.svh"

module fetch_sva
   import fetch_cache_pkg::*;
(
   input logic          clk_i,
   input logic          rst_i,
   input wb_req_t       wb_i,
   input logic          wb_ack_i,
   input fetch_bundle_t bundle_i,
   input logic          valid_i,
   input logic          ready_i,
   input logic          redirect_i
);

   // classic cycles, cyc tracks stb
   a_cyc_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_i.cyc == wb_i.stb)
      else $error("wishbone cyc differs from stb");

   // address held while the beat waits for ack
   a_adr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_i.stb && !wb_ack_i |=> $stable(wb_i.adr))
      else $error("wishbone address moved before ack");

   // back-pressure keeps the bundle, unless a redirect drops it
   a_bundle_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      valid_i && !ready_i && !redirect_i |=> valid_i && $stable(bundle_i))
      else $error("bundle changed or dropped while stalled");

   a_stb_reset: assert property (@(posedge clk_i)
      rst_i |=> !wb_i.stb)
      else $error("wishbone stb high during reset");

endmodule

bind fetch_top fetch_sva sva0 (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .wb_i       (wb_o),
   .wb_ack_i   (wb_ack_i),
   .bundle_i   (bundle_o),
   .valid_i    (bundle_valid_o),
   .ready_i    (bundle_ready_i),
   .redirect_i (redirect_i)
);

/* tb_fetch.sv */
`timescale 1ns/1ps
`include "fetch_cache_macros.svh"

module tb_fetch
   import fetch_cache_pkg::*;
();

   localparam logic [`ADDR_W-1:0] START_PC = 'h1f40;
   localparam int WAIT_LIMIT = 20000;

   logic               clk;
   logic               rst;
   logic               redirect;
   logic [`ADDR_W-1:0] target;
   logic               ready;
   wb_req_t            wb;
   logic [15:0]        wb_dat;
   logic               wb_ack;
   fetch_bundle_t      bundle;
   logic               bundle_valid;

   // stimulus control shared with the driver
   integer             seed = 32'h3c3;
   logic [31:0]        rnd;
   logic               stall_en;
   logic               redir_req;
   logic [`ADDR_W-1:0] redir_tgt;
   logic               aborted;

   // scoreboard state
   logic [`ADDR_W-1:0] exp_pc;
   fetch_bundle_t      exp_b;
   fetch_bundle_t      held;
   logic               stalled;
   wb_req_t            want_wb;
   logic [`ADDR_W-1:0] fill_base;
   int                 fill_beat = 0;
   int                 fills_seen = 0;
   int                 wb_beats = 0;
   int                 n_acc = 0;
   int                 errors = 0;
   int                 checks = 0;
   int                 tests = 0;
   int                 err0;
   int                 beats0;
   int                 rst_cycles = 0;
   logic [`ADDR_W-1:0] tgt;

   tb_clock clk0 (
      .clk_o (clk),
      .rst_o (rst)
   );

   tb_wb_mem mem0 (
      .clk_i (clk),
      .rst_i (rst),
      .wb_i  (wb),
      .dat_o (wb_dat),
      .ack_o (wb_ack)
   );

   fetch_top dut0 (
      .clk_i          (clk),
      .rst_i          (rst),
      .reset_pc_i     (START_PC),
      .redirect_i     (redirect),
      .target_i       (target),
      .wb_o           (wb),
      .wb_dat_i       (wb_dat),
      .wb_ack_i       (wb_ack),
      .bundle_o       (bundle),
      .bundle_valid_o (bundle_valid),
      .bundle_ready_i (ready)
   );

   // same content rule as the memory model
   function automatic logic [15:0] mem_word(input logic [`ADDR_W-1:0] a);
      return a[15:0] ^ a[`ADDR_W-1:16];
   endfunction

   // length rule: bit 15 or 00 -> 2, 01 -> 4, 10/11 -> 6
   function automatic logic [2:0] ref_len(input logic [15:0] op);
      if (op[15] || op[14:13] == 2'b00)
         return 3'd2;
      else if (op[14:13] == 2'b01)
         return 3'd4;
      return 3'd6;
   endfunction

   function automatic fetch_bundle_t ref_bundle(input logic [`ADDR_W-1:0] pc);
      fetch_bundle_t b;
      b.pc     = pc;
      b.opcode = mem_word(pc);
      b.imm    = {mem_word(pc + `ADDR_W'(2)), mem_word(pc + `ADDR_W'(4))};
      b.len    = ref_len(b.opcode);
      return b;
   endfunction

   function automatic logic [`ADDR_W-1:0] line_base(input logic [`ADDR_W-1:0] a);
      return a & ~`ADDR_W'(2 * `LINE_HW - 1);
   endfunction

   task automatic compare_bundle(input fetch_bundle_t got, input fetch_bundle_t want,
                                 input string what);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("mismatch at %0t: %s pc %h op %h imm %h len %0d", $time, what,
                  got.pc, got.opcode, got.imm, got.len);
         $display("   expected pc %h op %h imm %h len %0d",
                  want.pc, want.opcode, want.imm, want.len);
      end
   endtask

   task automatic compare_wb_req(input wb_req_t got, input wb_req_t want, input string what);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("mismatch at %0t: %s adr %h sel %b cyc %b stb %b, expected adr %h",
                  $time, what, got.adr, got.sel, got.cyc, got.stb, want.adr);
      end
   endtask

   task automatic abort_run(input string why);
      errors++;
      aborted = 1'b1;
      $display("timeout at %0t: %s", $time, why);
   endtask

   task automatic wait_accepts(input int count);
      int cycles;
      cycles = 0;
      while (n_acc < count && !aborted)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            abort_run("bundles stopped arriving");
      end
   endtask

   // returns on the edge where the dut samples the redirect
   task automatic redirect_to(input logic [`ADDR_W-1:0] t);
      int cycles;
      cycles    = 0;
      redir_tgt = t;
      redir_req = 1'b1;
      while ((redir_req || !redirect) && !aborted)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > 20)
            abort_run("redirect was never applied");
      end
   endtask

   // a fill in flight always runs to its last beat
   task automatic settle_fill();
      int cycles;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
         if (cycles > 200)
            abort_run("line fill did not finish");
      end
      while ((wb.stb || fill_beat != 0) && !aborted);
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      tests++;
      $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "failed");
   endtask

   // single driver for redirect, target and ready
   initial
   begin
      redirect  = 1'b0;
      target    = '0;
      ready     = 1'b0;
      stall_en  = 1'b0;
      redir_req = 1'b0;
      redir_tgt = '0;
      aborted   = 1'b0;
   end

   always @(posedge clk)
   begin
      rnd = $random(seed);
      if (rst)
      begin
         redirect <= 1'b0;
         ready    <= 1'b0;
      end
      else if (redir_req)
      begin
         // ready low so the redirect edge never also accepts a bundle
         redirect  <= 1'b1;
         target    <= redir_tgt;
         ready     <= 1'b0;
         redir_req = 1'b0;
      end
      else
      begin
         redirect <= 1'b0;
         ready    <= stall_en ? rnd[0] : 1'b1;
      end
   end

   // bundle side scoreboard
   always @(posedge clk)
   begin
      if (rst)
      begin
         exp_pc  <= START_PC;
         stalled <= 1'b0;
      end
      else
      begin
         // held bundle must survive a stall untouched
         if (stalled)
         begin
            if (!bundle_valid)
            begin
               errors++;
               $display("bundle was withdrawn while stalled at %0t", $time);
            end
            else
               compare_bundle(bundle, held, "stalled bundle");
         end
         stalled <= bundle_valid && !ready && !redirect;
         held    <= bundle;
         if (redirect)
            exp_pc <= target;
         else if (bundle_valid && ready)
         begin
            exp_b = ref_bundle(exp_pc);
            compare_bundle(bundle, exp_b, "accepted bundle");
            exp_pc <= exp_pc + `ADDR_W'(exp_b.len);
            n_acc  <= n_acc + 1;
         end
      end
   end

   // wishbone side, every beat checked against a 16 beat line walk
   always @(posedge clk)
   begin
      if (!rst && wb.stb && wb_ack)
      begin
         want_wb.adr = (fill_beat == 0) ? line_base(wb.adr)
                                        : fill_base + `ADDR_W'(2 * fill_beat);
         want_wb.sel = 2'b11;
         want_wb.cyc = 1'b1;
         want_wb.stb = 1'b1;
         compare_wb_req(wb, want_wb, "fill beat");
         if (fill_beat == 0)
         begin
            fill_base  <= line_base(wb.adr);
            fills_seen <= fills_seen + 1;
         end
         fill_beat <= (fill_beat == `LINE_HW - 1) ? 0 : fill_beat + 1;
         wb_beats  <= wb_beats + 1;
      end
   end

   initial
   begin
      // reset state, then the first bundle comes from the reset pc
      err0 = errors;
      while (rst && !aborted)
      begin
         @(posedge clk);
         rst_cycles++;
         if (rst_cycles > 20)
            abort_run("reset was never released");
      end
      checks++;
      if (bundle_valid || wb.stb || wb.cyc)
      begin
         errors++;
         $display("mismatch at %0t: valid %b stb %b cyc %b after reset, expected all low",
                  $time, bundle_valid, wb.stb, wb.cyc);
      end
      wait_accepts(1);
      report_test(1, "reset and first bundle", err0);

      // cold sequential run, crosses from 2 byte to 4 byte opcodes at 0x2000
      err0 = errors;
      wait_accepts(200);
      report_test(2, "cold sequential run", err0);

      err0 = errors;
      checks++;
      if (fills_seen == 0)
      begin
         errors++;
         $display("no line fills were seen during the cold run");
      end
      report_test(3, "line fill addresses", err0);

      // same range again, all lines already present
      err0 = errors;
      redirect_to(START_PC);
      settle_fill();
      beats0 = wb_beats;
      wait_accepts(n_acc + 200);
      checks++;
      if (wb_beats != beats0)
      begin
         errors++;
         $display("mismatch at %0t: %0d wishbone beats on cached rerun, expected 0",
                  $time, wb_beats - beats0);
      end
      report_test(4, "cached rerun", err0);

      err0 = errors;
      stall_en = 1'b1;
      wait_accepts(n_acc + 150);
      report_test(5, "random back-pressure", err0);

      // even targets anywhere in the first 64 KiB
      err0 = errors;
      repeat (20)
      begin
         tgt = $random(seed) & 32'h0000_fffe;
         redirect_to(tgt);
         wait_accepts(n_acc + 8);
      end
      report_test(6, "random redirects", err0);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* fetch_cache.f */
+incdir+.
fetch_cache_pkg.sv
icache.sv
fetch_sequencer.sv
fetch_top.sv
tb_clock.sv
tb_wb_mem.sv
fetch_sva.sv
tb_fetch.sv

/* run.sh */
#!/bin/sh
# compile the fetch testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_fetch \
   -f fetch_cache.f -o tb_fetch_sim

# status of the pipeline is the status of grep
./obj_dir/tb_fetch_sim | tee /dev/stderr | grep "Finished with no errors" > /dev/null
